// File: source/tlb_pkg.sv
package tlb_pkg;

    localparam int VPPN_W = 19;

    typedef logic [VPPN_W-1:0] vppn_t;
    typedef logic [9:0]        asid_t;
    typedef logic [19:0]       ppn_t;
    typedef logic [5:0]        ps_t;
    typedef logic [1:0]        plv_t;
    typedef logic [1:0]        mat_t;

    localparam ps_t PS_4K = 6'd12;
    localparam ps_t PS_2M = 6'd21;

    // lowest vppn bit compared for a 2 MB page.
    localparam int HUGE_VPPN_LSB = 9;

    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_page_t;

    // one entry maps an even/odd page pair.
    typedef struct packed {
        logic      e;
        vppn_t     vppn;
        ps_t       ps;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef enum logic [4:0] {
        INV_ALL      = 5'd0,
        INV_ALL_ALT  = 5'd1,
        INV_GLOBAL   = 5'd2,
        INV_LOCAL    = 5'd3,
        INV_ASID     = 5'd4,
        INV_ASID_VA  = 5'd5,
        INV_GASID_VA = 5'd6
    } inv_op_t;

    // vppn compare that honours the page size of the entry.
    function automatic logic vppn_hit(tlb_entry_t ent, vppn_t vppn);
        logic hit;
        if (ent.ps == PS_2M) begin
            hit = ent.vppn[VPPN_W-1:HUGE_VPPN_LSB] == vppn[VPPN_W-1:HUGE_VPPN_LSB];
        end else begin
            hit = ent.vppn == vppn;
        end
        return hit;
    endfunction

endpackage

// File: source/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array #(
    parameter int TLBNUM = 16
) (
    input  logic                                aclk,
    input  logic                                rst,
    input  logic                                we,
    input  logic [$clog2(TLBNUM)-1:0]           w_index,
    input  tlb_pkg::tlb_entry_t                 w_entry,
    input  logic [TLBNUM-1:0]                   kill_mask,
    input  logic [$clog2(TLBNUM)-1:0]           r_index,
    output tlb_pkg::tlb_entry_t                 r_entry,
    output tlb_pkg::tlb_entry_t [TLBNUM-1:0]    entries
);

    logic [TLBNUM-1:0]                  e_q;     // per-entry exist bits.
    logic [TLBNUM-1:0]                  w_sel;   // one-hot write select.
    tlb_pkg::tlb_entry_t [TLBNUM-1:0]   data_q;

    assign w_sel = we ? (TLBNUM'(1) << w_index) : '0;

    // kill first, then the write on top of it.
    always_ff @(posedge aclk) begin
        if (rst) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < TLBNUM; i++) begin
                if (w_sel[i]) begin
                    e_q[i] <= w_entry.e;
                end else if (kill_mask[i]) begin
                    e_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (we) begin
            data_q[w_index] <= w_entry;
        end
    end

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            entries[i]   = data_q[i];
            entries[i].e = e_q[i];  // stored e is stale after a kill.
        end
    end

    assign r_entry = entries[r_index];

endmodule

// File: source/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup #(
    parameter int TLBNUM = 16
) (
    input  tlb_pkg::tlb_entry_t [TLBNUM-1:0]    entries,
    input  tlb_pkg::vppn_t                      s_vppn,
    input  logic                                s_va_bit12,
    input  tlb_pkg::asid_t                      s_asid,
    output logic                                s_found,
    output logic [$clog2(TLBNUM)-1:0]           s_index,
    output tlb_pkg::ps_t                        s_ps,
    output tlb_pkg::tlb_page_t                  s_page
);

    localparam int IDX_W = $clog2(TLBNUM);

    logic [TLBNUM-1:0]      match;
    logic [IDX_W-1:0]       hit_idx;
    tlb_pkg::tlb_entry_t    hit_entry;
    logic                   odd;

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            match[i] = entries[i].e
                    && tlb_pkg::vppn_hit(entries[i], s_vppn)
                    && (entries[i].g || entries[i].asid == s_asid);
        end
    end

    // lowest index wins.
    always_comb begin
        hit_idx = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit_entry = entries[hit_idx];

    // 2 MB pages split on va bit 21, which is vppn bit 8.
    assign odd = (hit_entry.ps == tlb_pkg::PS_2M) ? s_vppn[tlb_pkg::HUGE_VPPN_LSB-1]
                                                  : s_va_bit12;

    assign s_found = |match;
    assign s_index = hit_idx;  // zero on a miss.
    assign s_ps    = s_found ? hit_entry.ps : '0;

    always_comb begin
        if (!s_found) begin
            s_page = '0;
        end else if (odd) begin
            s_page = hit_entry.page1;
        end else begin
            s_page = hit_entry.page0;
        end
    end

endmodule

// File: source/tlb_inv_ctrl.sv
`timescale 1ns/1ps

module tlb_inv_ctrl #(
    parameter int TLBNUM = 16
) (
    input  tlb_pkg::tlb_entry_t [TLBNUM-1:0]    entries,
    input  logic                                invtlb_valid,
    input  tlb_pkg::inv_op_t                    invtlb_op,
    input  tlb_pkg::asid_t                      invtlb_asid,
    input  tlb_pkg::vppn_t                      invtlb_vppn,
    output logic [TLBNUM-1:0]                   kill_mask
);

    logic [TLBNUM-1:0] is_g;
    logic [TLBNUM-1:0] asid_eq;
    logic [TLBNUM-1:0] va_eq;

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            is_g[i]    = entries[i].g;
            asid_eq[i] = entries[i].asid == invtlb_asid;
            va_eq[i]   = tlb_pkg::vppn_hit(entries[i], invtlb_vppn);
        end
    end

    always_comb begin
        kill_mask = '0;
        if (invtlb_valid) begin
            case (invtlb_op)
                tlb_pkg::INV_ALL,
                tlb_pkg::INV_ALL_ALT: begin
                    kill_mask = '1;
                end
                tlb_pkg::INV_GLOBAL: begin
                    kill_mask = is_g;
                end
                tlb_pkg::INV_LOCAL: begin
                    kill_mask = ~is_g;
                end
                tlb_pkg::INV_ASID: begin
                    kill_mask = ~is_g & asid_eq;
                end
                tlb_pkg::INV_ASID_VA: begin
                    kill_mask = ~is_g & asid_eq & va_eq;
                end
                tlb_pkg::INV_GASID_VA: begin
                    kill_mask = (is_g | asid_eq) & va_eq;  // global or own asid.
                end
                default: begin
                    kill_mask = '0;  // reserved op has no effect.
                end
            endcase
        end
    end

endmodule

// File: source/tlb_top.sv
`timescale 1ns/1ps

module tlb_top #(
    parameter int TLBNUM = 16
) (
    input  logic                        aclk,
    input  logic                        rst,

    input  tlb_pkg::vppn_t              s0_vppn,
    input  logic                        s0_va_bit12,
    input  tlb_pkg::asid_t              s0_asid,
    output logic                        s0_found,
    output logic [$clog2(TLBNUM)-1:0]   s0_index,
    output tlb_pkg::ppn_t               s0_ppn,
    output tlb_pkg::ps_t                s0_ps,
    output tlb_pkg::plv_t               s0_plv,
    output tlb_pkg::mat_t               s0_mat,
    output logic                        s0_d,
    output logic                        s0_v,

    input  tlb_pkg::vppn_t              s1_vppn,
    input  logic                        s1_va_bit12,
    input  tlb_pkg::asid_t              s1_asid,
    output logic                        s1_found,
    output logic [$clog2(TLBNUM)-1:0]   s1_index,
    output tlb_pkg::ppn_t               s1_ppn,
    output tlb_pkg::ps_t                s1_ps,
    output tlb_pkg::plv_t               s1_plv,
    output tlb_pkg::mat_t               s1_mat,
    output logic                        s1_d,
    output logic                        s1_v,

    input  logic                        invtlb_valid,
    input  tlb_pkg::inv_op_t            invtlb_op,
    input  tlb_pkg::asid_t              invtlb_asid,
    input  tlb_pkg::vppn_t              invtlb_vppn,

    input  logic                        we,
    input  logic [$clog2(TLBNUM)-1:0]   w_index,
    input  logic                        w_e,
    input  tlb_pkg::vppn_t              w_vppn,
    input  tlb_pkg::ps_t                w_ps,
    input  tlb_pkg::asid_t              w_asid,
    input  logic                        w_g,
    input  tlb_pkg::ppn_t               w_ppn0,
    input  tlb_pkg::plv_t               w_plv0,
    input  tlb_pkg::mat_t               w_mat0,
    input  logic                        w_d0,
    input  logic                        w_v0,
    input  tlb_pkg::ppn_t               w_ppn1,
    input  tlb_pkg::plv_t               w_plv1,
    input  tlb_pkg::mat_t               w_mat1,
    input  logic                        w_d1,
    input  logic                        w_v1,

    input  logic [$clog2(TLBNUM)-1:0]   r_index,
    output logic                        r_e,
    output tlb_pkg::vppn_t              r_vppn,
    output tlb_pkg::ps_t                r_ps,
    output tlb_pkg::asid_t              r_asid,
    output logic                        r_g,
    output tlb_pkg::ppn_t               r_ppn0,
    output tlb_pkg::plv_t               r_plv0,
    output tlb_pkg::mat_t               r_mat0,
    output logic                        r_d0,
    output logic                        r_v0,
    output tlb_pkg::ppn_t               r_ppn1,
    output tlb_pkg::plv_t               r_plv1,
    output tlb_pkg::mat_t               r_mat1,
    output logic                        r_d1,
    output logic                        r_v1
);

    tlb_pkg::tlb_entry_t [TLBNUM-1:0]   entries;
    tlb_pkg::tlb_entry_t                w_entry;
    tlb_pkg::tlb_entry_t                r_entry;
    tlb_pkg::tlb_page_t                 s0_page;
    tlb_pkg::tlb_page_t                 s1_page;
    logic [TLBNUM-1:0]                  kill_mask;

    // concatenation order follows the struct fields.
    assign w_entry = {w_e, w_vppn, w_ps, w_asid, w_g,
                      w_ppn0, w_plv0, w_mat0, w_d0, w_v0,
                      w_ppn1, w_plv1, w_mat1, w_d1, w_v1};

    assign {r_e, r_vppn, r_ps, r_asid, r_g,
            r_ppn0, r_plv0, r_mat0, r_d0, r_v0,
            r_ppn1, r_plv1, r_mat1, r_d1, r_v1} = r_entry;

    assign {s0_ppn, s0_plv, s0_mat, s0_d, s0_v} = s0_page;
    assign {s1_ppn, s1_plv, s1_mat, s1_d, s1_v} = s1_page;

    tlb_entry_array #(.TLBNUM(TLBNUM)) u_entry_array (
        .aclk      (aclk     ),
        .rst       (rst      ),
        .we        (we       ),
        .w_index   (w_index  ),
        .w_entry   (w_entry  ),
        .kill_mask (kill_mask),
        .r_index   (r_index  ),
        .r_entry   (r_entry  ),
        .entries   (entries  )
    );

    tlb_inv_ctrl #(.TLBNUM(TLBNUM)) u_inv_ctrl (
        .entries      (entries     ),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op   ),
        .invtlb_asid  (invtlb_asid ),
        .invtlb_vppn  (invtlb_vppn ),
        .kill_mask    (kill_mask   )
    );

    tlb_lookup #(.TLBNUM(TLBNUM)) u_lookup_s0 (
        .entries    (entries    ),
        .s_vppn     (s0_vppn    ),
        .s_va_bit12 (s0_va_bit12),
        .s_asid     (s0_asid    ),
        .s_found    (s0_found   ),
        .s_index    (s0_index   ),
        .s_ps       (s0_ps      ),
        .s_page     (s0_page    )
    );

    tlb_lookup #(.TLBNUM(TLBNUM)) u_lookup_s1 (
        .entries    (entries    ),
        .s_vppn     (s1_vppn    ),
        .s_va_bit12 (s1_va_bit12),
        .s_asid     (s1_asid    ),
        .s_found    (s1_found   ),
        .s_index    (s1_index   ),
        .s_ps       (s1_ps      ),
        .s_page     (s1_page    )
    );

endmodule

// File: tb/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb;

    localparam int TLBNUM   = 16;
    localparam int IDX_W    = $clog2(TLBNUM);
    localparam int STEP_MAX = 128;

    typedef logic [IDX_W-1:0] idx_t;

    // one row of the table; port 0 is s0, port 1 is s1.
    typedef struct packed {
        logic                       do_write;
        logic                       do_inv;
        idx_t                       w_index;
        tlb_pkg::tlb_entry_t        w_entry;
        logic [4:0]                 op;
        tlb_pkg::asid_t             inv_asid;
        tlb_pkg::vppn_t             inv_vppn;
        tlb_pkg::vppn_t [1:0]       s_vppn;
        logic [1:0]                 s_b12;
        tlb_pkg::asid_t [1:0]       s_asid;
        logic [1:0]                 exp_found;
        idx_t [1:0]                 exp_index;
        tlb_pkg::ps_t [1:0]         exp_ps;
        tlb_pkg::tlb_page_t [1:0]   exp_page;
        logic [1:0]                 rd_chk;     // 1 checks r_e, 2 the whole entry.
        idx_t                       r_index;
        tlb_pkg::tlb_entry_t        exp_entry;
    } step_t;

    logic aclk = 1'b0;
    logic rst;

    tlb_pkg::vppn_t     s0_vppn, s1_vppn;
    logic               s0_va_bit12, s1_va_bit12;
    tlb_pkg::asid_t     s0_asid, s1_asid;
    logic               s0_found, s1_found;
    idx_t               s0_index, s1_index;
    tlb_pkg::ppn_t      s0_ppn, s1_ppn;
    tlb_pkg::ps_t       s0_ps, s1_ps;
    tlb_pkg::plv_t      s0_plv, s1_plv;
    tlb_pkg::mat_t      s0_mat, s1_mat;
    logic               s0_d, s1_d, s0_v, s1_v;

    logic               invtlb_valid;
    tlb_pkg::inv_op_t   invtlb_op;
    tlb_pkg::asid_t     invtlb_asid;
    tlb_pkg::vppn_t     invtlb_vppn;

    logic               we, w_e, w_g, w_d0, w_v0, w_d1, w_v1;
    idx_t               w_index;
    tlb_pkg::vppn_t     w_vppn;
    tlb_pkg::ps_t       w_ps;
    tlb_pkg::asid_t     w_asid;
    tlb_pkg::ppn_t      w_ppn0, w_ppn1;
    tlb_pkg::plv_t      w_plv0, w_plv1;
    tlb_pkg::mat_t      w_mat0, w_mat1;

    idx_t               r_index;
    logic               r_e, r_g, r_d0, r_v0, r_d1, r_v1;
    tlb_pkg::vppn_t     r_vppn;
    tlb_pkg::ps_t       r_ps;
    tlb_pkg::asid_t     r_asid;
    tlb_pkg::ppn_t      r_ppn0, r_ppn1;
    tlb_pkg::plv_t      r_plv0, r_plv1;
    tlb_pkg::mat_t      r_mat0, r_mat1;

    tlb_pkg::tlb_page_t     s0_got, s1_got;
    tlb_pkg::tlb_entry_t    r_got;

    step_t  steps [0:STEP_MAX-1];
    int     n_steps = 0;
    int     cur = 0;
    int     errors = 0;
    int     seed;
    logic   built = 1'b0;

    tlb_pkg::tlb_entry_t    ent_a, ent_b, ent_c, ent_d, ent_e;
    tlb_pkg::asid_t         asid_a, asid_b, asid_c, asid_other;

    tlb_top #(.TLBNUM(TLBNUM)) DUT (.*);

    assign s0_got = {s0_ppn, s0_plv, s0_mat, s0_d, s0_v};
    assign s1_got = {s1_ppn, s1_plv, s1_mat, s1_d, s1_v};
    assign r_got  = {r_e, r_vppn, r_ps, r_asid, r_g,
                     r_ppn0, r_plv0, r_mat0, r_d0, r_v0,
                     r_ppn1, r_plv1, r_mat1, r_d1, r_v1};

    always #50 aclk = ~aclk;

    initial begin
        wait (built);
        #((n_steps + 20) * 100);
        $display("Timeout: the step table did not finish in the expected time");
        $display("Test failed");
        $finish;
    end

    function automatic tlb_pkg::tlb_entry_t make_entry(tlb_pkg::vppn_t vppn, tlb_pkg::ps_t ps,
            tlb_pkg::asid_t asid, logic g, tlb_pkg::plv_t plv);
        tlb_pkg::tlb_entry_t ent;
        ent.e          = 1'b1;
        ent.vppn       = vppn;
        ent.ps         = ps;
        ent.asid       = asid;
        ent.g          = g;
        ent.page0.ppn  = tlb_pkg::ppn_t'($random(seed));
        ent.page0.plv  = plv;
        ent.page0.mat  = 2'd1;
        ent.page0.d    = 1'b1;
        ent.page0.v    = 1'b1;
        ent.page1.ppn  = tlb_pkg::ppn_t'($random(seed));
        ent.page1.plv  = ~plv;
        ent.page1.mat  = 2'd2;
        ent.page1.d    = 1'b0;
        ent.page1.v    = 1'b1;
        return ent;
    endfunction

    task automatic new_step();
        cur = n_steps;
        steps[cur] = '0;  // vppn 0 holds no entry, so a miss.
        n_steps++;
    endtask

    task automatic add_write(idx_t idx, tlb_pkg::tlb_entry_t ent);
        new_step();
        steps[cur].do_write = 1'b1;
        steps[cur].w_index  = idx;
        steps[cur].w_entry  = ent;
    endtask

    task automatic add_inv(logic [4:0] op, tlb_pkg::asid_t asid, tlb_pkg::vppn_t vppn);
        new_step();
        steps[cur].do_inv   = 1'b1;
        steps[cur].op       = op;
        steps[cur].inv_asid = asid;
        steps[cur].inv_vppn = vppn;
    endtask

    // a miss expects zero on every search output.
    task automatic set_port(logic p, tlb_pkg::vppn_t vppn, logic b12, tlb_pkg::asid_t asid,
            logic hit, idx_t idx, tlb_pkg::ps_t ps, tlb_pkg::tlb_page_t page);
        steps[cur].s_vppn[p]    = vppn;
        steps[cur].s_b12[p]     = b12;
        steps[cur].s_asid[p]    = asid;
        steps[cur].exp_found[p] = hit;
        steps[cur].exp_index[p] = hit ? idx : '0;
        steps[cur].exp_ps[p]    = hit ? ps : '0;
        steps[cur].exp_page[p]  = hit ? page : '0;
    endtask

    task automatic add_read(idx_t idx, logic [1:0] mode, tlb_pkg::tlb_entry_t exp);
        new_step();
        steps[cur].rd_chk    = mode;
        steps[cur].r_index   = idx;
        steps[cur].exp_entry = exp;
    endtask

    task automatic write_all();
        add_write(4'd3, ent_a);
        add_write(4'd5, ent_b);
        add_write(4'd7, ent_d);
        add_write(4'd9, ent_c);
        add_write(4'd11, ent_e);
    endtask

    // three searches that show which of the five entries are present.
    task automatic probe(logic a, logic b, logic d, logic c, logic e);
        new_step();
        set_port(1'b0, 19'h12345, 1'b0, asid_other, a, 4'd3, ent_a.ps, ent_a.page0);
        set_port(1'b1, 19'h2A3AB, 1'b0, asid_b, b, 4'd5, ent_b.ps, ent_b.page1);
        new_step();
        set_port(1'b0, 19'h00777, 1'b1, asid_c, d | e, d ? 4'd7 : 4'd11, tlb_pkg::PS_4K,
                 d ? ent_d.page1 : ent_e.page1);
        set_port(1'b1, 19'h00778, 1'b0, asid_c, c, 4'd9, ent_c.ps, ent_c.page0);
        new_step();
        set_port(1'b0, 19'h00777, 1'b0, asid_other, e, 4'd11, ent_e.ps, ent_e.page0);
        set_port(1'b1, 19'h12345, 1'b1, asid_b, a, 4'd3, ent_a.ps, ent_a.page1);
    endtask

    task drive_step(input step_t st);
        we           <= st.do_write;
        w_index      <= st.w_index;
        {w_e, w_vppn, w_ps, w_asid, w_g} <= {st.w_entry.e, st.w_entry.vppn, st.w_entry.ps,
                                             st.w_entry.asid, st.w_entry.g};
        {w_ppn0, w_plv0, w_mat0, w_d0, w_v0} <= st.w_entry.page0;
        {w_ppn1, w_plv1, w_mat1, w_d1, w_v1} <= st.w_entry.page1;
        invtlb_valid <= st.do_inv;
        invtlb_op    <= tlb_pkg::inv_op_t'(st.op);
        invtlb_asid  <= st.inv_asid;
        invtlb_vppn  <= st.inv_vppn;
        s0_vppn      <= st.s_vppn[0];
        s0_va_bit12  <= st.s_b12[0];
        s0_asid      <= st.s_asid[0];
        s1_vppn      <= st.s_vppn[1];
        s1_va_bit12  <= st.s_b12[1];
        s1_asid      <= st.s_asid[1];
        r_index      <= st.r_index;
    endtask

    task automatic check_found(string what, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: step %0d %s got %0b, expected %0b",
                     $time, cur, what, got, exp);
        end
    endtask

    task automatic check_index(string what, idx_t got, idx_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: step %0d %s got %0d, expected %0d",
                     $time, cur, what, got, exp);
        end
    endtask

    task automatic check_ps(string what, tlb_pkg::ps_t got, tlb_pkg::ps_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: step %0d %s got %0d, expected %0d",
                     $time, cur, what, got, exp);
        end
    endtask

    task automatic check_page(string what, tlb_pkg::tlb_page_t got, tlb_pkg::tlb_page_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: step %0d %s got %h, expected %h",
                     $time, cur, what, got, exp);
        end
    endtask

    task automatic check_entry(string what, tlb_pkg::tlb_entry_t got,
            tlb_pkg::tlb_entry_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: step %0d %s got %h, expected %h",
                     $time, cur, what, got, exp);
        end
    endtask

    initial begin
        logic [4:0]             keep [0:7];
        tlb_pkg::tlb_entry_t    dead_a;
        seed = 75921;
        rst = 1'b1;
        drive_step('0);

        asid_c     = tlb_pkg::asid_t'($random(seed));
        asid_b     = asid_c ^ 10'h155;
        asid_a     = asid_c ^ 10'h0f0;
        asid_other = asid_c ^ 10'h3ff;
        ent_a = make_entry(19'h12345, tlb_pkg::PS_4K, asid_a, 1'b1, 2'd0);
        ent_b = make_entry(19'h2A200, tlb_pkg::PS_2M, asid_b, 1'b0, 2'd1);
        ent_d = make_entry(19'h00777, tlb_pkg::PS_4K, asid_c, 1'b0, 2'd3);
        ent_c = make_entry(19'h00778, tlb_pkg::PS_4K, asid_c, 1'b0, 2'd2);
        ent_e = make_entry(19'h00777, tlb_pkg::PS_4K, asid_b, 1'b1, 2'd0);
        dead_a   = ent_a;
        dead_a.e = 1'b0;

        for (int i = 0; i < TLBNUM; i++) begin
            add_read(idx_t'(i), 2'd1, '0);  // e low after reset.
        end
        probe(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        write_all();
        probe(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
        new_step();
        set_port(1'b0, 19'h12345, 1'b1, asid_c, 1'b1, 4'd3, ent_a.ps, ent_a.page1);
        set_port(1'b1, 19'h12344, 1'b0, asid_a, 1'b0, 4'd0, '0, '0);
        new_step();  // 2 MB page ignores va bit 12.
        set_port(1'b0, 19'h2A2FF, 1'b1, asid_b, 1'b1, 4'd5, ent_b.ps, ent_b.page0);
        set_port(1'b1, 19'h2A400, 1'b0, asid_b, 1'b0, 4'd0, '0, '0);
        new_step();  // 7 beats 11 on s1.
        set_port(1'b0, 19'h2A200, 1'b0, asid_other, 1'b0, 4'd0, '0, '0);
        set_port(1'b1, 19'h00777, 1'b0, asid_c, 1'b1, 4'd7, ent_d.ps, ent_d.page0);
        add_read(4'd5, 2'd2, ent_b);
        add_read(4'd9, 2'd2, ent_c);

        // survivor bits per op in a b d c e order.
        keep = '{5'b00000, 5'b00000, 5'b01110, 5'b10001,
                 5'b11001, 5'b11011, 5'b11010, 5'b11111};
        for (int op = 0; op < 8; op++) begin
            write_all();
            add_inv(5'(op), asid_c, 19'h00777);
            probe(keep[op][4], keep[op][3], keep[op][2], keep[op][1], keep[op][0]);
        end
        add_inv(5'd5, asid_b, 19'h2A3FF);  // matches the 2 MB entry on upper bits.
        probe(1'b1, 1'b0, 1'b1, 1'b1, 1'b1);

        add_write(4'd7, ent_d);
        steps[cur].do_inv = 1'b1;  // op 0 in the same cycle.
        add_read(4'd7, 2'd2, ent_d);
        add_read(4'd3, 2'd2, dead_a);
        probe(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        built = 1'b1;

        repeat (2) @(posedge aclk);
        rst <= 1'b0;
        for (int i = 0; i < n_steps; i++) begin
            @(posedge aclk);
            drive_step(steps[i]);
            @(negedge aclk);
            cur = i;
            check_found("s0_found", s0_found, steps[i].exp_found[0]);
            check_index("s0_index", s0_index, steps[i].exp_index[0]);
            check_ps("s0_ps", s0_ps, steps[i].exp_ps[0]);
            check_page("s0_page", s0_got, steps[i].exp_page[0]);
            check_found("s1_found", s1_found, steps[i].exp_found[1]);
            check_index("s1_index", s1_index, steps[i].exp_index[1]);
            check_ps("s1_ps", s1_ps, steps[i].exp_ps[1]);
            check_page("s1_page", s1_got, steps[i].exp_page[1]);
            if (steps[i].rd_chk == 2'd1) begin
                check_found("r_e", r_e, steps[i].exp_entry.e);
            end else if (steps[i].rd_chk == 2'd2) begin
                check_entry("r_entry", r_got, steps[i].exp_entry);
            end
        end
        @(posedge aclk);
        drive_step('0);

        $display("Ran %0d steps, %0d errors", n_steps, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
source/tlb_pkg.sv
source/tlb_entry_array.sv
source/tlb_lookup.sv
source/tlb_inv_ctrl.sv
source/tlb_top.sv
tb/tlb_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TLB testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tlb_tb -f build.f -o tlb_sim

out=$(./obj_dir/tlb_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi
